// ==== bench/tb_omega_tasks.svh ====
`ifndef TB_OMEGA_TASKS_SVH
`define TB_OMEGA_TASKS_SVH

    task automatic check_valid(input logic exp, input logic got);
        if (got !== exp) begin
            valid_errors++;
            $display("ERR %0t out_valid expected %b actual %b", $time, exp, got);
        end
    endtask

    task automatic check_block(
        input omega_pkg::omega_block_u exp,
        input omega_pkg::omega_block_u got
    );
        if (got.flat !== exp.flat) begin
            data_errors++;
            $display("ERR %0t data_out expected %h actual %h", $time, exp.flat, got.flat);
        end
    endtask

    // drive 1 ns after the edge, sample at the falling edge
    task automatic step_cycle(
        input  logic          v,
        input  logic [BW-1:0] d,
        output logic          ov,
        output logic [BW-1:0] od
    );
        @(posedge clk);
        #1;
        in_valid = v;
        data_in = d;
        @(negedge clk);
        ov = out_valid;
        od = data_out;
    endtask

    task automatic push_block(input logic v, input logic [BW-1:0] blk);
        stim_valid.push_back(v);
        stim_block.push_back(blk);
    endtask

    // block driven in step j shows up in the sample of step j + 2
    task automatic run_stream();
        int n;
        logic ov;
        logic [BW-1:0] od;
        omega_pkg::omega_block_u exp_u;
        omega_pkg::omega_block_u got_u;

        n = stim_valid.size();
        for (int j = 0; j < n + 2; j++) begin
            if (j < n) begin
                step_cycle(stim_valid[j], stim_block[j], ov, od);
            end else begin
                step_cycle(1'b0, '0, ov, od);
            end
            if (j < 2) begin
                check_valid(1'b0, ov);
            end else begin
                check_valid(stim_valid[j-2], ov);
                if (stim_valid[j-2]) begin
                    exp_u.flat = model_block(stim_block[j-2]);
                    got_u.flat = od;
                    check_block(exp_u, got_u);
                end
            end
        end
        stim_valid.delete();
        stim_block.delete();
    endtask

    task automatic test_idle_after_reset();
        for (int i = 0; i < IDLE_LEN; i++) begin
            push_block(1'b0, rand_block());
        end
        run_stream();
    endtask

    // first pass reads the coefficients directly, second pass forces reduction
    task automatic test_unit_blocks();
        logic [7:0] v;
        logic [31:0] w;
        logic [BW-1:0] blk;

        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < DIM; k++) begin
                for (int c = 0; c < DIM; c++) begin
                    w = rand_word();
                    v = (pass == 0) ? 8'h01 : (w[31:24] | 8'h80);
                    blk = '0;
                    blk[120 - 32 * k - 8 * c +: 8] = v;
                    push_block(1'b1, blk);
                end
            end
        end
        run_stream();
    endtask

    task automatic test_row_xor();
        logic [BW-1:0] blk;
        logic [7:0] x;
        omega_pkg::omega_block_u exp_u;
        omega_pkg::omega_block_u got_u;

        for (int p = 0; p < 2; p++) begin
            if (p == 0) begin
                blk = {BW{1'b1}};
            end else begin
                blk = {32'hAAAA_AAAA, 32'h5555_5555, 32'hCCCC_CCCC, 32'h0F0F_0F0F};
            end
            push_block(1'b1, blk);
            run_stream();

            // expected row 0 is the plain xor of the input rows
            exp_u.flat = model_block(blk);
            for (int c = 0; c < DIM; c++) begin
                x = 8'h00;
                for (int k = 0; k < DIM; k++) begin
                    x = x ^ byte_at(blk, k, c);
                end
                exp_u.flat[120 - 8 * c +: 8] = x;
            end
            // data_out still holds the last result
            got_u.flat = data_out;
            check_block(exp_u, got_u);
        end
    endtask

    task automatic test_random_blocks();
        int count;
        logic [31:0] w;

        count = 0;
        while (count < RAND_COUNT) begin
            w = rand_word();
            if (w[16] && count > 0) begin
                push_block(1'b0, rand_block());
            end
            push_block(1'b1, rand_block());
            count++;
        end
        run_stream();
    endtask

    task automatic test_burst_and_gaps();
        logic [GAP_LEN-1:0] gaps;

        for (int i = 0; i < BURST_LEN; i++) begin
            push_block(1'b1, rand_block());
        end
        run_stream();

        gaps = 16'b1011_0010_1110_0101;
        for (int i = GAP_LEN - 1; i >= 0; i--) begin
            push_block(gaps[i], rand_block());
        end
        run_stream();
    endtask

`endif

// ==== bench/tb_omega_mix.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_omega_mix;

    localparam int DIM = omega_pkg::MAT_DIM;
    localparam int BW = omega_pkg::BLOCK_W;

    // stream lengths in cycles plus two drain cycles per stream
    localparam int IDLE_LEN = 6;
    localparam int UNIT_LEN = 2 * DIM * DIM;
    localparam int ROW_LEN = 2 * (1 + 2);
    localparam int RAND_COUNT = 20;
    localparam int RAND_MAX_LEN = 2 * RAND_COUNT;
    localparam int BURST_LEN = 10;
    localparam int GAP_LEN = 16;
    localparam int CYCLE_LIMIT = 2 + (IDLE_LEN + 2) + (UNIT_LEN + 2) + ROW_LEN
        + (RAND_MAX_LEN + 2) + (BURST_LEN + 2) + (GAP_LEN + 2) + 50;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic [BW-1:0] data_in;
    logic          out_valid;
    logic [BW-1:0] data_out;

    int valid_errors;
    int data_errors;
    int cycle_count = 0;
    logic [31:0] lcg_state;

    // one entry per driven cycle of the next stream
    logic          stim_valid [$];
    logic [BW-1:0] stim_block [$];

    // byte (r, c) of a flat block
    function automatic logic [7:0] byte_at(
        input logic [BW-1:0] blk,
        input int r,
        input int c
    );
        return blk[120 - 32 * r - 8 * c +: 8];
    endfunction

    // carry-less product, then fold the high byte with 0x11D
    function automatic logic [7:0] gf_mul_ref(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] wide;

        wide = '0;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                wide = wide ^ ({8'h00, a} << i);
            end
        end
        for (int i = 15; i >= 8; i--) begin
            if (wide[i]) begin
                wide = wide ^ (16'h011D << (i - 8));
            end
        end
        return wide[7:0];
    endfunction

    function automatic logic [7:0] gen_of(input int r);
        case (r)
            0: return 8'h01;
            1: return 8'h02;
            2: return 8'h06;
            default: return 8'h08;
        endcase
    endfunction

    // coefficient of row r is generator r to the power k
    function automatic logic [7:0] coef_ref(input int r, input int k);
        logic [7:0] p;

        p = 8'h01;
        for (int i = 0; i < k; i++) begin
            p = gf_mul_ref(p, gen_of(r));
        end
        return p;
    endfunction

    function automatic logic [BW-1:0] model_block(input logic [BW-1:0] blk);
        logic [BW-1:0] res;
        logic [7:0] acc;

        res = '0;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                acc = 8'h00;
                for (int k = 0; k < DIM; k++) begin
                    acc = acc ^ gf_mul_ref(coef_ref(r, k), byte_at(blk, k, c));
                end
                res[120 - 32 * r - 8 * c +: 8] = acc;
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [BW-1:0] rand_block();
        logic [BW-1:0] b;

        b = '0;
        for (int i = 0; i < 4; i++) begin
            b = {b[BW-33:0], rand_word()};
        end
        return b;
    endfunction

    `include "tb_omega_tasks.svh"

    omega_mix omega_mix_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .out_valid (out_valid),
        .data_out  (data_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        data_in = '0;
        valid_errors = 0;
        data_errors = 0;
        lcg_state = 32'd27;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_idle_after_reset();
        test_unit_blocks();
        test_row_xor();
        test_random_blocks();
        test_burst_and_gaps();

        $display("valid errors: %0d, data errors: %0d", valid_errors, data_errors);
        if (valid_errors + data_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
hw/omega_pkg.sv
hw/omega_prod_if.sv
hw/omega_scale_stage.sv
hw/omega_reduce_stage.sv
hw/omega_mix.sv
bench/tb_omega_mix.sv

// ==== hw/omega_mix.sv ====
`timescale 1ns/1ps
`default_nettype none

module omega_mix (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [omega_pkg::BLOCK_W-1:0] data_in,
    output logic                          out_valid,
    output logic [omega_pkg::BLOCK_W-1:0] data_out
);

    omega_pkg::omega_block_u data_in_u;
    omega_pkg::omega_block_u data_out_u;

    // flat ports to matrix view and back
    assign data_in_u.flat = data_in;
    assign data_out       = data_out_u.flat;

    // scaled products between the two stages
    omega_prod_if prod_if ();

    // stage 1 computes the coefficient products
    omega_scale_stage scale_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .data_in  (data_in_u),
        .prod     (prod_if.scale_mp)
    );

    // stage 2 xors the products down each column
    omega_reduce_stage reduce_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prod      (prod_if.reduce_mp),
        .out_valid (out_valid),
        .data_out  (data_out_u)
    );

endmodule

`default_nettype wire

// ==== hw/omega_pkg.sv ====
`default_nettype none

package omega_pkg;

    // matrix geometry
    localparam int MAT_DIM = 4;
    localparam int BYTE_W = 8;
    localparam int BLOCK_W = MAT_DIM * MAT_DIM * BYTE_W;

    typedef logic [BYTE_W-1:0] gf_byte_t;

    // low byte of x^8 + x^4 + x^3 + x^2 + 1
    localparam gf_byte_t GF_POLY_LOW = 8'h1D;

    // row r holds powers 0..3 of generator 1, 2, 6, 8
    localparam gf_byte_t [0:MAT_DIM-1][0:MAT_DIM-1] OMEGA_COEF = '{
        '{8'h01, 8'h01, 8'h01, 8'h01},
        '{8'h01, 8'h02, 8'h04, 8'h08},
        '{8'h01, 8'h06, 8'h14, 8'h78},
        '{8'h01, 8'h08, 8'h40, 8'h3A}
    };

    // one block seen flat or as a byte matrix
    // mat[0][0] sits in the top byte, row 0 fills the top word
    typedef union packed {
        logic [BLOCK_W-1:0] flat;
        gf_byte_t [0:MAT_DIM-1][0:MAT_DIM-1] mat;
    } omega_block_u;

    // multiply by x, fold the carry back in
    function automatic gf_byte_t gf_xtime(input gf_byte_t a);
        gf_byte_t shifted;

        shifted = {a[BYTE_W-2:0], 1'b0};
        if (a[BYTE_W-1]) begin
            shifted = shifted ^ GF_POLY_LOW;
        end
        return shifted;
    endfunction

    // shift-and-add product
    // coef is a table constant, so this folds down to a small XOR net
    function automatic gf_byte_t gf_mul_const(
        input gf_byte_t a,
        input gf_byte_t coef
    );
        gf_byte_t acc;
        gf_byte_t term;

        acc = '0;
        term = a;
        for (int i = 0; i < BYTE_W; i++) begin
            if (coef[i]) begin
                acc = acc ^ term;
            end
            term = gf_xtime(term);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

// ==== hw/omega_prod_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface omega_prod_if;

    logic valid;

    // products for output row N, indexed [k][c]
    omega_pkg::gf_byte_t [0:omega_pkg::MAT_DIM-1][0:omega_pkg::MAT_DIM-1] prod_row0;
    omega_pkg::gf_byte_t [0:omega_pkg::MAT_DIM-1][0:omega_pkg::MAT_DIM-1] prod_row1;
    omega_pkg::gf_byte_t [0:omega_pkg::MAT_DIM-1][0:omega_pkg::MAT_DIM-1] prod_row2;
    omega_pkg::gf_byte_t [0:omega_pkg::MAT_DIM-1][0:omega_pkg::MAT_DIM-1] prod_row3;

    modport scale_mp (
        output valid,
        output prod_row0,
        output prod_row1,
        output prod_row2,
        output prod_row3
    );

    modport reduce_mp (
        input valid,
        input prod_row0,
        input prod_row1,
        input prod_row2,
        input prod_row3
    );

endinterface

`default_nettype wire

// ==== hw/omega_reduce_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module omega_reduce_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    omega_prod_if.reduce_mp          prod,
    output logic                     out_valid,
    output omega_pkg::omega_block_u  data_out
);

    // rows gathered so the reduction can loop over r
    omega_pkg::gf_byte_t [0:omega_pkg::MAT_DIM-1][0:omega_pkg::MAT_DIM-1]
        row_prod [0:omega_pkg::MAT_DIM-1];

    omega_pkg::omega_block_u sum_next;

    assign row_prod[0] = prod.prod_row0;
    assign row_prod[1] = prod.prod_row1;
    assign row_prod[2] = prod.prod_row2;
    assign row_prod[3] = prod.prod_row3;

    // out(r, c) = xor over k of the scaled bytes
    always_comb begin
        sum_next.flat = '0;
        for (int r = 0; r < omega_pkg::MAT_DIM; r++) begin
            for (int c = 0; c < omega_pkg::MAT_DIM; c++) begin
                for (int k = 0; k < omega_pkg::MAT_DIM; k++) begin
                    sum_next.mat[r][c] = sum_next.mat[r][c] ^ row_prod[r][k][c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prod.valid) begin
            data_out <= sum_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/omega_scale_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module omega_scale_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  omega_pkg::omega_block_u data_in,
    omega_prod_if.scale_mp          prod
);

    // prod_next[r][k][c] = M[r][k] * in(k, c)
    omega_pkg::gf_byte_t [0:omega_pkg::MAT_DIM-1][0:omega_pkg::MAT_DIM-1]
        prod_next [0:omega_pkg::MAT_DIM-1];

    always_comb begin
        for (int r = 0; r < omega_pkg::MAT_DIM; r++) begin
            for (int k = 0; k < omega_pkg::MAT_DIM; k++) begin
                for (int c = 0; c < omega_pkg::MAT_DIM; c++) begin
                    prod_next[r][k][c] = omega_pkg::gf_mul_const(
                        data_in.mat[k][c],
                        omega_pkg::OMEGA_COEF[r][k]
                    );
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod.valid <= 1'b0;
        end else begin
            prod.valid <= in_valid;
        end
    end

    // product registers hold while no block is presented
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod.prod_row0 <= prod_next[0];
            prod.prod_row1 <= prod_next[1];
            prod.prod_row2 <= prod_next[2];
            prod.prod_row3 <= prod_next[3];
        end
    end

endmodule

`default_nettype wire
